/* include/dcache_config.svh */
// ------------------------------------------------------------
// data cache geometry macros: address split, line, beat
// and burst RAM sizes with the RAM load rule
// ------------------------------------------------------------
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// client word and byte address
`define DC_ADDR_W         32
`define DC_DATA_W         32
`define DC_BYTES          4
`define DC_BYTE_OFF_W     2

// address split |tag|line|word|byte|
`define DC_WORD_IX_W      3
`define DC_LINE_IX_W      2
`define DC_TAG_W          (`DC_ADDR_W - `DC_LINE_IX_W - `DC_WORD_IX_W - `DC_BYTE_OFF_W)
`define DC_LINES          (1 << `DC_LINE_IX_W)
`define DC_WORDS_PER_LINE (1 << `DC_WORD_IX_W)

// burst RAM, one line is DC_BURST_LEN beats
`define DC_BEAT_W         64
`define DC_BEAT_BYTES     (`DC_BEAT_W / 8)
`define DC_BEAT_OFF_W     3
`define DC_BURST_LEN      4
`define DC_BEAT_IX_W      2
`define DC_WORDS_PER_BEAT (`DC_BEAT_W / `DC_DATA_W)
`define DC_RAM_AW         8
`define DC_RAM_DEPTH      (1 << `DC_RAM_AW)
`define DC_RAM_INIT_BASE  32'hA500_0000

`endif

/* hdl/dcache_pkg.sv */
// ------------------------------------------------------------
// data cache types: address decode union, client request,
// burst RAM command and response
// ------------------------------------------------------------
`include "dcache_config.svh"

package dcache_pkg;

  // lookup view of a byte address
  typedef struct packed {
    logic [`DC_TAG_W-1:0]      tag;
    logic [`DC_LINE_IX_W-1:0]  line_ix;
    logic [`DC_WORD_IX_W-1:0]  word_ix;
    logic [`DC_BYTE_OFF_W-1:0] byte_off;
  } dc_addr_fields_t;

  // raw view feeds the RAM line number, f view feeds the tag compare
  typedef union packed {
    logic [`DC_ADDR_W-1:0] raw;
    dc_addr_fields_t       f;
  } dc_addr_t;

  // client request
  typedef struct packed {
    logic                  write;
    dc_addr_t              addr;
    // byte enables, only looked at for writes
    logic [`DC_BYTES-1:0]  be;
    logic [`DC_DATA_W-1:0] wdata;
  } dc_req_t;

  // burst RAM command
  typedef struct packed {
    logic                      write;
    // first beat of the line
    logic [`DC_RAM_AW-1:0]     beat_addr;
    // beat 0 on the command cycle, later beats follow
    logic [`DC_BEAT_W-1:0]     wdata;
    logic [`DC_BEAT_BYTES-1:0] mask;
  } ram_cmd_t;

  // burst RAM read beat
  typedef struct packed {
    logic [`DC_BEAT_W-1:0] rdata;
    logic                  valid;
  } ram_rsp_t;

endpackage

/* hdl/burst_ram.sv */
// ------------------------------------------------------------
// burst RAM: 256 x 64-bit beats, four-beat line transfers,
// preloaded with base plus word index
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_config.svh"

module burst_ram (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::ram_cmd_t cmd,
  input  logic                 cmd_en,
  output dcache_pkg::ram_rsp_t rsp,
  output logic                 busy
);
  import dcache_pkg::*;

  localparam logic [`DC_BEAT_IX_W-1:0] LAST_BEAT = `DC_BEAT_IX_W'(`DC_BURST_LEN - 1);

  logic [`DC_BEAT_W-1:0]    mem [`DC_RAM_DEPTH];
  logic                     active_q;
  logic                     write_q;
  logic [`DC_RAM_AW-1:0]    base_q;
  logic [`DC_BEAT_IX_W-1:0] cnt_q;
  logic                     rd_valid_q;
  logic [`DC_BEAT_W-1:0]    rd_data_q;

  logic                     start;
  logic                     wr_en;
  logic [`DC_RAM_AW-1:0]    cur_addr;

  // each 32-bit word holds base + its word index
  initial begin
    for (int b = 0; b < `DC_RAM_DEPTH; b++) begin
      for (int i = 0; i < `DC_WORDS_PER_BEAT; i++) begin
        mem[b][i*`DC_DATA_W +: `DC_DATA_W] = `DC_RAM_INIT_BASE + b * `DC_WORDS_PER_BEAT + i;
      end
    end
  end

  assign start    = cmd_en & ~active_q;
  // beat 0 of a write comes with the command, rest while active
  assign wr_en    = (start & cmd.write) | (active_q & write_q);
  assign cur_addr = active_q ? base_q + `DC_RAM_AW'(cnt_q) : cmd.beat_addr;

  // busy until the last read beat has been presented
  assign busy      = active_q | rd_valid_q;
  assign rsp.rdata = rd_data_q;
  assign rsp.valid = rd_valid_q;

  // burst sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      active_q   <= 1'b0;
      write_q    <= 1'b0;
      cnt_q      <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= active_q & ~write_q;
      if (start) begin
        active_q <= 1'b1;
        write_q  <= cmd.write;
        // write already stored beat 0
        cnt_q    <= cmd.write ? `DC_BEAT_IX_W'(1) : '0;
      end else if (active_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LAST_BEAT) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      base_q <= cmd.beat_addr;
    end
    // read beat registered, two cycles after the command
    if (active_q & ~write_q) begin
      rd_data_q <= mem[cur_addr];
    end
  end

  // masked beat write
  always @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `DC_BEAT_BYTES; b++) begin
        if (cmd.mask[b]) begin
          mem[cur_addr][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* hdl/dcache_ctrl.sv */
// ------------------------------------------------------------
// direct-mapped write-back cache controller: line storage,
// tag compare, write-back and fill FSM
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  input  dcache_pkg::dc_req_t   req,
  input  dcache_pkg::ram_rsp_t  ram_rsp,
  input  logic                  ram_busy,
  output logic [`DC_DATA_W-1:0] rdata,
  output logic                  rdata_ready,
  output logic                  busy,
  output dcache_pkg::ram_cmd_t  ram_cmd,
  output logic                  ram_cmd_en
);
  import dcache_pkg::*;

  // one-hot state bit positions
  localparam int S_IDLE      = 0;
  localparam int S_WB        = 1;
  localparam int S_FILL_WAIT = 2;
  localparam int S_FILL      = 3;
  localparam int S_MERGE     = 4;

  localparam logic [`DC_BEAT_IX_W-1:0] LAST_BEAT = `DC_BEAT_IX_W'(`DC_BURST_LEN - 1);

  logic [4:0]                state_q;
  logic [`DC_LINES-1:0]      valid_q;
  logic [`DC_LINES-1:0]      dirty_q;
  logic [`DC_TAG_W-1:0]      tag_q  [`DC_LINES];
  logic [`DC_DATA_W-1:0]     data_q [`DC_LINES][`DC_WORDS_PER_LINE];
  dc_req_t                   req_q;
  // beat on the RAM bus, shared by write-back and fill
  logic [`DC_BEAT_IX_W-1:0]  beat_cnt;

  logic                      accept;
  logic                      hit;
  logic                      victim_dirty;
  logic                      fill_beat;
  logic                      want_beat;
  logic                      merge_go;
  logic [`DC_LINE_IX_W-1:0]  lix;
  logic [`DC_LINE_IX_W-1:0]  lix_q;
  logic [`DC_WORD_IX_W-1:0]  wix_q;
  logic [`DC_WORD_IX_W-`DC_BEAT_IX_W-1:0] half_q;

  function automatic logic [4:0] st(input int ix);
    return 5'b1 << ix;
  endfunction

  // first beat address of the line at tag/line_ix
  function automatic logic [`DC_RAM_AW-1:0] beat_base(
    input logic [`DC_TAG_W-1:0]     tag,
    input logic [`DC_LINE_IX_W-1:0] line_ix
  );
    dc_addr_t a;
    a = '0;
    a.f.tag = tag;
    a.f.line_ix = line_ix;
    return a.raw[`DC_RAM_AW+`DC_BEAT_OFF_W-1:`DC_BEAT_OFF_W];
  endfunction

  // pack words of one beat, lowest word in the low half
  function automatic logic [`DC_BEAT_W-1:0] line_beat(
    input logic [`DC_LINE_IX_W-1:0] line_ix,
    input logic [`DC_BEAT_IX_W-1:0] k
  );
    logic [`DC_BEAT_W-1:0] b;
    for (int i = 0; i < `DC_WORDS_PER_BEAT; i++) begin
      b[i*`DC_DATA_W +: `DC_DATA_W] = data_q[line_ix][int'(k) * `DC_WORDS_PER_BEAT + i];
    end
    return b;
  endfunction

  // byte-masked word update
  function automatic logic [`DC_DATA_W-1:0] merge_word(
    input logic [`DC_DATA_W-1:0] old_w,
    input logic [`DC_DATA_W-1:0] new_w,
    input logic [`DC_BYTES-1:0]  be
  );
    logic [`DC_DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < `DC_BYTES; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // live decode for the lookup, latched decode for the miss
  assign lix    = req.addr.f.line_ix;
  assign lix_q  = req_q.addr.f.line_ix;
  assign wix_q  = req_q.addr.f.word_ix;
  // word within its beat
  assign half_q = wix_q[`DC_WORD_IX_W-`DC_BEAT_IX_W-1:0];

  assign busy         = ~state_q[S_IDLE];
  assign accept       = enable & ~busy;
  assign hit          = valid_q[lix] && (tag_q[lix] == req.addr.f.tag);
  assign victim_dirty = valid_q[lix] & dirty_q[lix];
  assign fill_beat    = (state_q[S_FILL_WAIT] | state_q[S_FILL]) & ram_rsp.valid;
  // beat carrying the word a read miss waits for
  assign want_beat    = ~req_q.write &&
                        (wix_q[`DC_WORD_IX_W-1 -: `DC_BEAT_IX_W] == beat_cnt);
  // leave merge only with the RAM idle, next miss issues at once
  assign merge_go     = state_q[S_MERGE] & ~ram_busy;

  // FSM, valid/dirty bits and pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= st(S_IDLE);
      valid_q     <= '0;
      dirty_q     <= '0;
      beat_cnt    <= '0;
      rdata_ready <= 1'b0;
      ram_cmd_en  <= 1'b0;
    end else begin
      // single-cycle pulses
      rdata_ready <= 1'b0;
      ram_cmd_en  <= 1'b0;
      case (1'b1)
        state_q[S_IDLE]: begin
          if (accept) begin
            if (hit) begin
              if (req.write) begin
                dirty_q[lix] <= 1'b1;
              end else begin
                rdata_ready <= 1'b1;
              end
            end else begin
              // dirty victim goes out first, else straight to fill
              ram_cmd_en <= 1'b1;
              beat_cnt   <= '0;
              state_q    <= victim_dirty ? st(S_WB) : st(S_FILL_WAIT);
            end
          end
        end
        state_q[S_WB]: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == LAST_BEAT) begin
            // fill command right after the last write beat
            ram_cmd_en <= 1'b1;
            state_q    <= st(S_FILL_WAIT);
          end
        end
        state_q[S_FILL_WAIT]: begin
          if (fill_beat) begin
            beat_cnt    <= beat_cnt + 1'b1;
            rdata_ready <= want_beat;
            state_q     <= st(S_FILL);
          end
        end
        state_q[S_FILL]: begin
          if (fill_beat) begin
            beat_cnt    <= beat_cnt + 1'b1;
            rdata_ready <= want_beat;
            if (beat_cnt == LAST_BEAT) begin
              state_q <= st(S_MERGE);
            end
          end
        end
        state_q[S_MERGE]: begin
          if (merge_go) begin
            valid_q[lix_q] <= 1'b1;
            // a write miss leaves the new line dirty
            dirty_q[lix_q] <= req_q.write;
            state_q        <= st(S_IDLE);
          end
        end
        default: state_q <= st(S_IDLE);
      endcase
    end
  end

  // line data, tags, latched request and RAM command payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
      if (hit) begin
        if (req.write) begin
          data_q[lix][req.addr.f.word_ix] <=
            merge_word(data_q[lix][req.addr.f.word_ix], req.wdata, req.be);
        end else begin
          rdata <= data_q[lix][req.addr.f.word_ix];
        end
      end else begin
        ram_cmd.write     <= victim_dirty;
        ram_cmd.mask      <= '1;
        ram_cmd.wdata     <= line_beat(lix, '0);
        // victim uses its stored tag, a fill uses the request tag
        ram_cmd.beat_addr <= victim_dirty ? beat_base(tag_q[lix], lix)
                                          : beat_base(req.addr.f.tag, lix);
      end
    end
    if (state_q[S_WB]) begin
      if (beat_cnt == LAST_BEAT) begin
        ram_cmd.write     <= 1'b0;
        ram_cmd.beat_addr <= beat_base(req_q.addr.f.tag, lix_q);
      end else begin
        ram_cmd.wdata <= line_beat(lix_q, beat_cnt + 1'b1);
      end
    end
    if (fill_beat) begin
      for (int i = 0; i < `DC_WORDS_PER_BEAT; i++) begin
        data_q[lix_q][int'(beat_cnt) * `DC_WORDS_PER_BEAT + i] <=
          ram_rsp.rdata[i*`DC_DATA_W +: `DC_DATA_W];
      end
      if (want_beat) begin
        rdata <= ram_rsp.rdata[half_q*`DC_DATA_W +: `DC_DATA_W];
      end
    end
    if (merge_go) begin
      tag_q[lix_q] <= req_q.addr.f.tag;
      // write-allocate, bytes land on the freshly filled word
      if (req_q.write) begin
        data_q[lix_q][wix_q] <= merge_word(data_q[lix_q][wix_q], req_q.wdata, req_q.be);
      end
    end
  end

endmodule

/* hdl/dcache_top.sv */
// ------------------------------------------------------------
// data cache top: controller in front of the burst RAM
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  input  dcache_pkg::dc_req_t   req,
  output logic [`DC_DATA_W-1:0] rdata,
  output logic                  rdata_ready,
  output logic                  busy
);
  import dcache_pkg::*;

  // controller to RAM
  ram_cmd_t ram_cmd;
  logic     ram_cmd_en;
  // RAM back to controller
  ram_rsp_t ram_rsp;
  logic     ram_busy;

  dcache_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .req         (req),
    .ram_rsp     (ram_rsp),
    .ram_busy    (ram_busy),
    .rdata       (rdata),
    .rdata_ready (rdata_ready),
    .busy        (busy),
    .ram_cmd     (ram_cmd),
    .ram_cmd_en  (ram_cmd_en)
  );

  burst_ram u_ram (
    .clk    (clk),
    .rst    (rst),
    .cmd    (ram_cmd),
    .cmd_en (ram_cmd_en),
    .rsp    (ram_rsp),
    .busy   (ram_busy)
  );

endmodule

/* dv/dcache_checker.sv */
// ------------------------------------------------------------
// controller and burst RAM protocol assertions, bound into
// every dcache_ctrl instance
// ------------------------------------------------------------
`timescale 1ns/1ps

module dcache_checker (
  input logic clk,
  input logic rst,
  input logic accept,
  input logic hit,
  input logic req_write,
  input logic busy,
  input logic rdata_ready,
  input logic ram_cmd_en,
  input logic ram_busy
);

  // RAM takes a command only while idle
  cmd_when_ram_idle: assert property (@(posedge clk) disable iff (rst)
    ram_cmd_en |-> !ram_busy)
    else $error("RAM command issued while the RAM was busy");

  // read pulse is one cycle wide
  single_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    rdata_ready |=> !rdata_ready)
    else $error("rdata_ready high in two consecutive cycles");

  // busy comes only from a miss taken on the previous edge
  busy_after_miss: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> $past(accept && !hit))
    else $error("busy rose without an accepted miss");

  // read hit answers on the next cycle
  read_hit_latency: assert property (@(posedge clk) disable iff (rst)
    (accept && hit && !req_write) |=> rdata_ready)
    else $error("read hit without rdata_ready one cycle later");

endmodule

bind dcache_ctrl dcache_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .accept      (accept),
  .hit         (hit),
  .req_write   (req.write),
  .busy        (busy),
  .rdata_ready (rdata_ready),
  .ram_cmd_en  (ram_cmd_en),
  .ram_busy    (ram_busy)
);

/* dv/dcache_tb.sv */
// ------------------------------------------------------------
// data cache testbench: clock, reset, random traffic against
// a shadow memory, result assertions and watchdog
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int RST_CYCLES   = 10;
  localparam int N_DIRECTED   = 8;
  localparam int N_RANDOM     = 200;
  localparam int N_OPS        = N_DIRECTED + N_RANDOM;
  localparam int OP_CYCLES    = 20;
  // one shadow word per RAM word over the full 2 KB
  localparam int SHADOW_WORDS = `DC_RAM_DEPTH * `DC_WORDS_PER_BEAT;
  localparam int N_COV        = 6;

  logic                  clk;
  logic                  rst;
  logic                  enable;
  dc_req_t               req;
  logic [`DC_DATA_W-1:0] rdata;
  logic                  rdata_ready;
  logic                  busy;

  logic [`DC_DATA_W-1:0] shadow [SHADOW_WORDS];
  // expected valid, dirty and tag per line index
  logic [`DC_LINES-1:0]  m_valid;
  logic [`DC_LINES-1:0]  m_dirty;
  logic [`DC_TAG_W-1:0]  m_tag [`DC_LINES];
  // reach count for fill read, read hit, write hit, dirty evict, write miss, ignored enable
  int                    cov [N_COV];
  logic [`DC_ADDR_W-1:0] read_log [$];

  dcache_top UUT (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .req         (req),
    .rdata       (rdata),
    .rdata_ready (rdata_ready),
    .busy        (busy)
  );

  always #20 clk = ~clk;

  task automatic stop_run(input string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_run("value check failed");
    end
  endtask

  function automatic dc_req_t make_req(input logic wr, input logic [31:0] addr,
                                       input logic [3:0] be, input logic [31:0] wdata);
    dc_req_t r;
    r.write    = wr;
    r.addr.raw = addr;
    r.be       = be;
    r.wdata    = wdata;
    return r;
  endfunction

  // byte enables widened to a bit mask
  function automatic logic [31:0] apply_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] be);
    logic [31:0] m;
    m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~m) | (new_w & m);
  endfunction

  // four tags on two line indices keep conflicts frequent
  function automatic logic [31:0] pick_addr();
    dc_addr_t a;
    a.raw       = '0;
    a.f.tag     = `DC_TAG_W'($urandom % 4);
    a.f.line_ix = `DC_LINE_IX_W'($urandom % 2);
    a.f.word_ix = `DC_WORD_IX_W'($urandom % `DC_WORDS_PER_LINE);
    return a.raw;
  endfunction

  // one client request where intrude holds a write on enable during the miss
  task automatic run_op(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                        input logic [31:0] wdata, input logic intrude);
    dc_addr_t a;
    int       wix;
    logic     exp_hit;
    logic [31:0] exp_word;
    int       pulses;
    int       k;
    a.raw   = addr;
    wix     = int'(addr >> `DC_BYTE_OFF_W);
    // wait for busy low sampled away from the edge
    @(negedge clk);
    while (busy) @(negedge clk);
    exp_hit = m_valid[a.f.line_ix] && (m_tag[a.f.line_ix] == a.f.tag);
    @(posedge clk);
    enable <= 1'b1;
    req    <= make_req(wr, addr, be, wdata);
    // accepted on this edge
    @(posedge clk);
    enable <= 1'b0;
    if (wr) begin
      shadow[wix] = apply_be(shadow[wix], wdata, be);
    end else begin
      read_log.push_back(addr);
    end
    exp_word = shadow[wix];
    if (exp_hit) begin
      cov[wr ? 2 : 1]++;
      m_dirty[a.f.line_ix] = m_dirty[a.f.line_ix] | wr;
    end else begin
      if (m_valid[a.f.line_ix] && m_dirty[a.f.line_ix]) cov[3]++;
      cov[wr ? 4 : 0]++;
      m_valid[a.f.line_ix] = 1'b1;
      m_dirty[a.f.line_ix] = wr;
      m_tag[a.f.line_ix]   = a.f.tag;
    end
    @(negedge clk);
    if (exp_hit) begin
      // hit answers in the next cycle without going busy
      check_eq("busy", busy, 1'b0);
      check_eq("rdata_ready", rdata_ready, !wr);
      if (!wr) check_eq("rdata", rdata, exp_word);
    end else begin
      check_eq("busy", busy, 1'b1);
      pulses = 0;
      k      = 0;
      while (busy) begin
        if (rdata_ready) begin
          pulses++;
          check_eq("rdata", rdata, exp_word);
        end
        if (intrude && k == 0) begin
          @(posedge clk);
          enable <= 1'b1;
          req    <= make_req(1'b1, pick_addr(), 4'hf, $urandom);
          cov[5]++;
        end
        if (intrude && k == 3) begin
          @(posedge clk);
          enable <= 1'b0;
        end
        k++;
        @(negedge clk);
      end
      // a read pulses once before busy falls and a write never pulses
      check_eq("rdata_ready pulses", 32'(pulses), wr ? 32'd0 : 32'd1);
      check_eq("rdata_ready", rdata_ready, 1'b0);
    end
  endtask

  // watchdog sized from the op count
  initial begin
    repeat (N_OPS * OP_CYCLES + RST_CYCLES) @(posedge clk);
    stop_run($sformatf("watchdog expired, the run did not finish in %0d cycles",
                       N_OPS * OP_CYCLES + RST_CYCLES));
  end

  initial begin
    logic        wr_r;
    logic [31:0] addr_r;
    logic [3:0]  be_r;
    logic [31:0] wdata_r;
    logic        intrude_r;
    int          missing;
    void'($urandom(62125));
    clk     = 1'b0;
    rst     = 1'b1;
    enable  = 1'b0;
    req     = '0;
    m_valid = '0;
    m_dirty = '0;
    missing = 0;
    for (int w = 0; w < SHADOW_WORDS; w++) begin
      shadow[w] = `DC_RAM_INIT_BASE + 32'(w);
    end
    for (int i = 0; i < N_COV; i++) begin
      cov[i] = 0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // fill, hit, write hit, dirty evict with ignored enable, refetch, write miss, line read
    run_op(1'b0, 32'h000, 4'h0, 32'h0, 1'b0);
    run_op(1'b0, 32'h004, 4'h0, 32'h0, 1'b0);
    run_op(1'b1, 32'h008, 4'b0101, 32'h1234_5678, 1'b0);
    run_op(1'b0, 32'h008, 4'h0, 32'h0, 1'b0);
    run_op(1'b0, 32'h080, 4'h0, 32'h0, 1'b1);
    run_op(1'b0, 32'h008, 4'h0, 32'h0, 1'b0);
    run_op(1'b1, 32'h1A4, 4'b1100, 32'hCAFE_F00D, 1'b0);
    run_op(1'b0, 32'h1B0, 4'h0, 32'h0, 1'b0);
    for (int n = 0; n < N_RANDOM; n++) begin
      wr_r      = 1'($urandom % 2);
      addr_r    = pick_addr();
      be_r      = 4'($urandom % 16);
      wdata_r   = $urandom;
      intrude_r = ($urandom % 4) == 0;
      run_op(wr_r, addr_r, be_r, wdata_r, intrude_r);
    end
    for (int i = 0; i < N_COV; i++) begin
      if (cov[i] == 0) begin
        $display("behavior %0d was never reached by the stimulus", i);
        missing++;
      end
    end
    $display("%0d reads checked against the shadow memory", read_log.size());
    if (missing != 0) begin
      stop_run("incomplete stimulus");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* sources.f */
+incdir+include
hdl/dcache_pkg.sv
hdl/burst_ram.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the data cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module dcache_tb \
  -o dcache_sim

./obj_dir/dcache_sim | tee "$LOG"

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi
